/* Makefile */
# Verilator build and run for the peripheral subsystem

VERILATOR  ?= verilator
TOP        ?= tb_periph_top
FILELIST   ?= periph_sys.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= -Wall

SHELL := /bin/bash

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	set -o pipefail; ./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	else \
		echo "simulation finished cleanly"; \
	fi

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* periph_sys.f */
+incdir+src
src/periph_pkg.sv
src/apb_decoder.sv
src/us_tick_gen.sv
src/mtimer.sv
src/uart_tx.sv
src/periph_top.sv
sim/tb_periph_top.sv

/* sim/tb_periph_top.sv */
// peripheral subsystem testbench
`timescale 1ns/100ps
`include "periph_params.svh"

module tb_periph_top;

	localparam int clk_period  = 40;
	localparam int tick_div    = 4;
	localparam int uart_clkdiv = 8;
	localparam int bit_time    = uart_clkdiv * clk_period;  // ns per uart bit
	// five uart frames, timer waits and the table, four times over
	localparam int max_cycles  = (5 * 10 * uart_clkdiv + 50 * tick_div + 100 * 4) * 4;

	localparam logic op_rd = 1'b0;
	localparam logic op_wr = 1'b1;
	localparam int   n_rows = 19;

	typedef struct packed {
		logic               wr;
		logic [`APB_AW-1:0] addr;
		logic [`APB_DW-1:0] wdata;
		logic [`APB_DW-1:0] rdata;  // expected on reads
		logic               err;
	} stim_row_t;

	logic               clk;
	logic               rst_n;
	logic               psel;
	logic               penable;
	logic               pwrite;
	logic [`APB_AW-1:0] paddr;
	logic [`APB_DW-1:0] pwdata;
	logic               dbg_halt;
	logic [`APB_DW-1:0] prdata;
	logic               pready;
	logic               pslverr;
	logic               timer_irq;
	logic               uart_tx;

	stim_row_t  stim [n_rows];
	logic [7:0] rx_q [$];   // bytes seen on the uart line
	logic [31:0] lcg_state = 32'd2994;
	logic       irq_snap;
	int         wait_states;
	int         errors = 0;
	int         checks = 0;
	int         n_tests = 0;
	int         test_base = 0;
	int         cycles = 0;

	periph_top #(
		.tick_div    (tick_div),
		.uart_clkdiv (uart_clkdiv)
	) periph_top_inst (.*);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// ------------------------------------------------------------------
	// helpers

	function automatic logic [7:0] lcg_byte();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];  // upper bits are the better ones
	endfunction

	task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
			input string msg);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED at %0d ns: %s, got %h expected %h",
				$time, msg, actual, expected);
		end
	endtask

	task automatic end_test(input string name);
		n_tests++;
		if (errors == test_base)
			$display("test %-28s ok", name);
		else
			$display("test %-28s failed with %0d errors", name, errors - test_base);
		test_base = errors;
	endtask

	// one apb transfer sampled mid-cycle in the completing access phase
	task automatic apb_access(input logic wr, input logic [`APB_AW-1:0] addr,
			input logic [`APB_DW-1:0] wdata, output logic [`APB_DW-1:0] rdata,
			output logic err);
		@(negedge clk);
		psel    = 1'b1;  // setup phase
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge clk);
		penable = 1'b1;
		wait_states = 0;
		#1;
		while (!pready) begin
			wait_states++;
			@(negedge clk);
			#1;
		end
		rdata    = prdata;
		err      = pslverr;
		irq_snap = timer_irq;
		@(negedge clk);  // completing edge has passed
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [`APB_AW-1:0] addr, input logic [`APB_DW-1:0] data,
			output logic err);
		logic [`APB_DW-1:0] unused_rd;
		apb_access(op_wr, addr, data, unused_rd, err);
	endtask

	task automatic apb_read(input logic [`APB_AW-1:0] addr, output logic [`APB_DW-1:0] data,
			output logic err);
		apb_access(op_rd, addr, '0, data, err);
	endtask

	task automatic run_rows(input int first, input int last);
		logic [`APB_DW-1:0] rd;
		logic               err;
		for (int i = first; i <= last; i++) begin
			if (stim[i].wr) begin
				apb_write(stim[i].addr, stim[i].wdata, err);
			end else begin
				apb_read(stim[i].addr, rd, err);
				check_eq(rd, stim[i].rdata, $sformatf("row %0d prdata", i));
			end
			check_eq(32'(err), 32'(stim[i].err), $sformatf("row %0d pslverr", i));
			// none of the table accesses may stall
			check_eq(32'(wait_states), 32'd0, $sformatf("row %0d wait states", i));
		end
	endtask

	task automatic expect_byte(input logic [7:0] exp, input string msg);
		while (rx_q.size() == 0)
			@(negedge clk);
		check_eq(32'(rx_q.pop_front()), 32'(exp), msg);
	endtask

	// ------------------------------------------------------------------
	// uart line monitor sampling 8N1 mid-bit

	initial begin : uart_monitor
		logic [7:0] data;
		wait (rst_n === 1'b1);
		forever begin
			@(negedge uart_tx);
			#(bit_time / 2);
			check_eq(32'(uart_tx), 32'd0, "uart start bit");
			for (int b = 0; b < 8; b++) begin
				#(bit_time);
				data[b] = uart_tx;  // lsb first
			end
			#(bit_time);
			check_eq(32'(uart_tx), 32'd1, "uart stop bit");
			rx_q.push_back(data);
		end
	end

	initial begin : watchdog
		while (cycles < max_cycles) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", max_cycles);
		$display("** FAIL **");
		$finish;
	end

	// ------------------------------------------------------------------
	// main sequence

	initial begin : main
		logic [`APB_DW-1:0] rd;
		logic [`APB_DW-1:0] t0;
		logic [`APB_DW-1:0] t1;
		logic               err;
		logic               irq_early;
		logic [7:0]         tx_a;
		logic [7:0]         tx_b;

		rst_n    = 1'b0;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		paddr    = '0;
		pwdata   = '0;
		dbg_halt = 1'b0;

		stim = '{
			'{op_rd, 16'h0004, 32'h0,        32'h0,        1'b0},  // mtime lo
			'{op_rd, 16'h0008, 32'h0,        32'h0,        1'b0},
			'{op_rd, 16'h000c, 32'h0,        32'hffffffff, 1'b0},  // mtimecmp lo
			'{op_rd, 16'h0010, 32'h0,        32'hffffffff, 1'b0},
			'{op_rd, 16'h0000, 32'h0,        32'h0,        1'b0},  // ctrl
			'{op_wr, 16'h000c, 32'h12345678, 32'h0,        1'b0},
			'{op_rd, 16'h000c, 32'h0,        32'h12345678, 1'b0},
			'{op_wr, 16'h0010, 32'h9abcdef0, 32'h0,        1'b0},
			'{op_rd, 16'h0010, 32'h0,        32'h9abcdef0, 1'b0},
			'{op_wr, 16'h0004, 32'ha5a50001, 32'h0,        1'b0},
			'{op_rd, 16'h0004, 32'h0,        32'ha5a50001, 1'b0},
			'{op_wr, 16'h0008, 32'h00000003, 32'h0,        1'b0},
			'{op_rd, 16'h0008, 32'h0,        32'h00000003, 1'b0},
			'{op_rd, 16'h8000, 32'h0,        32'h0,        1'b1},  // select 2
			'{op_wr, 16'hc004, 32'h11111111, 32'h0,        1'b1},  // select 3
			'{op_rd, 16'h0014, 32'h0,        32'h0,        1'b1},  // timer offset 5
			'{op_wr, 16'h0018, 32'h22222222, 32'h0,        1'b1},
			'{op_rd, 16'h4008, 32'h0,        32'h0,        1'b1},  // uart offset 2
			'{op_rd, 16'h4004, 32'h0,        32'h0,        1'b0}   // uart status, idle
		};

		repeat (8) @(negedge clk);
		rst_n = 1'b1;

		run_rows(0, 12);
		end_test("register reset and readback");
		run_rows(13, 18);
		end_test("unmapped access");

		// count from zero up to a compare of 5
		apb_write(16'h0008, 32'h0, err);
		apb_write(16'h0004, 32'h0, err);
		apb_write(16'h0010, 32'h0, err);
		apb_write(16'h000c, 32'd5, err);
		apb_write(16'h0000, 32'd1, err);
		irq_early = 1'b0;
		do begin
			apb_read(16'h0004, rd, err);
			if (rd < 32'd5 && irq_snap)
				irq_early = 1'b1;
		end while (!irq_snap);
		check_eq(32'(irq_early), 32'd0, "timer_irq high before mtime reached 5");
		apb_read(16'h0004, rd, err);
		check_eq(32'(rd >= 32'd5), 32'd1, "mtime at least 5 after timer_irq");
		end_test("counting and interrupt");

		@(negedge clk);
		dbg_halt = 1'b1;
		apb_read(16'h0004, t0, err);
		repeat (3 * tick_div + 2) @(negedge clk);
		apb_read(16'h0004, t1, err);
		check_eq(t1, t0, "mtime frozen under dbg_halt");
		dbg_halt = 1'b0;
		repeat (2 * tick_div + 2) @(negedge clk);
		apb_read(16'h0004, rd, err);
		check_eq(32'(rd > t1), 32'd1, "mtime counts after dbg_halt release");
		end_test("debug halt");

		for (int i = 0; i < 3; i++) begin
			tx_a = lcg_byte();
			apb_write(16'h4000, 32'(tx_a), err);
			check_eq(32'(err), 32'd0, "txdata write pslverr");
			expect_byte(tx_a, $sformatf("uart frame %0d data", i));
		end
		end_test("uart frame");

		tx_a = lcg_byte();
		tx_b = lcg_byte();
		apb_write(16'h4000, 32'(tx_a), err);
		apb_read(16'h4004, rd, err);
		check_eq(rd, 32'd1, "status busy during frame");
		apb_write(16'h4000, 32'(tx_b), err);
		check_eq(32'(wait_states > 0), 32'd1, "second txdata write stalled");
		check_eq(32'(err), 32'd0, "stalled txdata write pslverr");
		expect_byte(tx_a, "first back-to-back byte");
		expect_byte(tx_b, "second back-to-back byte");
		end_test("back-pressure");

		$display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

/* src/apb_decoder.sv */
// apb address decoder
`timescale 1ns/100ps
`include "periph_params.svh"

module apb_decoder (
	input  logic               psel,
	input  logic [`APB_AW-1:0] paddr,
	input  logic               timer_pready,
	input  logic [`APB_DW-1:0] timer_prdata,
	input  logic               timer_pslverr,
	input  logic               uart_pready,
	input  logic [`APB_DW-1:0] uart_prdata,
	input  logic               uart_pslverr,
	output logic               timer_psel,
	output logic               uart_psel,
	output logic               pready,
	output logic [`APB_DW-1:0] prdata,
	output logic               pslverr
);
	import periph_pkg::*;

	slave_sel_e sel;

	always_comb begin
		case (paddr[`SEL_MSB:`SEL_LSB])
			2'd0:    sel = SEL_TIMER;
			2'd1:    sel = SEL_UART;
			default: sel = SEL_NONE;
		endcase
	end

	assign timer_psel = psel && (sel == SEL_TIMER);
	assign uart_psel  = psel && (sel == SEL_UART);

	// ---------------------------------------------------------------------
	// response mux

	always_comb begin
		case (sel)
			SEL_TIMER: begin
				pready  = timer_pready;
				prdata  = timer_prdata;
				pslverr = timer_pslverr;
			end
			SEL_UART: begin
				pready  = uart_pready;
				prdata  = uart_prdata;
				pslverr = uart_pslverr;
			end
			default: begin
				// no slave here so answer at once with an error
				pready  = 1'b1;
				prdata  = '0;
				pslverr = psel;
			end
		endcase
	end

	// at most one peripheral sees the select
	always_comb begin
		assert (!(timer_psel && uart_psel))
			else $error("apb_decoder: timer and uart selected together");
	end

endmodule

/* src/mtimer.sv */
// risc-v machine timer
`timescale 1ns/100ps
`include "periph_params.svh"

module mtimer (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  logic [`APB_AW-1:0] paddr,
	input  logic [`APB_DW-1:0] pwdata,
	input  logic               tick,
	input  logic               dbg_halt,
	output logic [`APB_DW-1:0] prdata,
	output logic               pready,
	output logic               pslverr,
	output logic               timer_irq
);
	import periph_pkg::*;

	logic        ctrl_en;
	logic [63:0] mtime;
	logic [63:0] mtimecmp;
	reg_off_e    off;
	logic        off_ok;
	logic        wr_en;
	logic        count_en;

	assign off      = reg_off_e'(paddr[`OFF_MSB:`OFF_LSB]);
	assign wr_en    = psel && penable && pwrite && off_ok;
	assign count_en = tick && ctrl_en && !dbg_halt;  // frozen while the hart is halted

	assign pready  = 1'b1;  // no wait states
	assign pslverr = psel && penable && !off_ok;

	// ---------------------------------------------------------------------
	// register read

	always_comb begin
		off_ok = 1'b1;
		prdata = '0;
		case (off)
			REG_CTRL:      prdata = {{(`APB_DW-1){1'b0}}, ctrl_en};
			REG_MTIME:     prdata = mtime[31:0];
			REG_MTIMEH:    prdata = mtime[63:32];
			REG_MTIMECMP:  prdata = mtimecmp[31:0];
			REG_MTIMECMPH: prdata = mtimecmp[63:32];
			default:       off_ok = 1'b0;
		endcase
	end

	// ---------------------------------------------------------------------
	// control and compare registers

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_en  <= 1'b0;
			mtimecmp <= '1;  // no interrupt until software sets a deadline
		end else if (wr_en) begin
			case (off)
				REG_CTRL:      ctrl_en <= pwdata[0];
				REG_MTIMECMP:  mtimecmp[31:0] <= pwdata;
				REG_MTIMECMPH: mtimecmp[63:32] <= pwdata;
				default:       ;
			endcase
		end
	end

	// a bus write to mtime wins over the increment
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtime <= '0;
		end else if (wr_en && off == REG_MTIME) begin
			mtime[31:0] <= pwdata;
		end else if (wr_en && off == REG_MTIMEH) begin
			mtime[63:32] <= pwdata;
		end else if (count_en) begin
			mtime <= mtime + 64'd1;
		end
	end

	// registered compare
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			timer_irq <= 1'b0;
		else
			timer_irq <= (mtime >= mtimecmp);
	end

	// a disarmed compare never fires unless mtime itself wrapped to the top
	assert property (@(posedge clk) disable iff (!rst_n)
		(mtimecmp == '1 && mtime != '1) |=> !timer_irq)
		else $error("mtimer: irq raised with mtimecmp at all ones");

endmodule

/* src/periph_params.svh */
// peripheral subsystem parameters
`ifndef PERIPH_PARAMS_SVH
`define PERIPH_PARAMS_SVH

// ---------------------------------------------------------------------
// apb bus widths

`define APB_AW 16
`define APB_DW 32

// ---------------------------------------------------------------------
// address map

// paddr[15:14] picks the peripheral
`define SEL_MSB 15
`define SEL_LSB 14

// word offset inside a peripheral
`define OFF_MSB 5
`define OFF_LSB 2

// ---------------------------------------------------------------------
// timing defaults that the top level parameters override

`define TICK_DIV    27   // 27 MHz core clock
`define UART_CLKDIV 234  // 115200 baud at 27 MHz

`endif

/* src/periph_pkg.sv */
// peripheral subsystem types
package periph_pkg;

	// decoded target of an apb access
	typedef enum logic [1:0] {
		SEL_TIMER = 2'd0,
		SEL_UART  = 2'd1,
		SEL_NONE  = 2'd2   // select field 2 or 3
	} slave_sel_e;

	// register word offsets, taken from paddr[5:2]
	typedef enum logic [3:0] {
		REG_CTRL      = 4'd0,
		REG_MTIME     = 4'd1,
		REG_MTIMEH    = 4'd2,
		REG_MTIMECMP  = 4'd3,
		REG_MTIMECMPH = 4'd4
	} reg_off_e;

	// uart offsets reuse the timer encodings in their own window
	localparam reg_off_e REG_TXDATA = REG_CTRL;
	localparam reg_off_e REG_STATUS = REG_MTIME;

endpackage

/* src/periph_top.sv */
// peripheral subsystem top level
`timescale 1ns/100ps
`include "periph_params.svh"

module periph_top #(
	parameter int tick_div    = `TICK_DIV,
	parameter int uart_clkdiv = `UART_CLKDIV
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  logic [`APB_AW-1:0] paddr,
	input  logic [`APB_DW-1:0] pwdata,
	input  logic               dbg_halt,
	output logic [`APB_DW-1:0] prdata,
	output logic               pready,
	output logic               pslverr,
	output logic               timer_irq,
	output logic               uart_tx
);
	logic               timer_psel;
	logic               timer_pready;
	logic [`APB_DW-1:0] timer_prdata;
	logic               timer_pslverr;
	logic               uart_psel;
	logic               uart_pready;
	logic [`APB_DW-1:0] uart_prdata;
	logic               uart_pslverr;
	logic               tick;

	apb_decoder apb_decoder_inst (.*);

	us_tick_gen #(
		.tick_div (tick_div)
	) us_tick_gen_inst (.*);

	// ---------------------------------------------------------------------
	// peripherals

	mtimer mtimer_inst (
		.*,
		.psel    (timer_psel),
		.prdata  (timer_prdata),
		.pready  (timer_pready),
		.pslverr (timer_pslverr)
	);

	uart_tx #(
		.clkdiv (uart_clkdiv)
	) uart_tx_inst (
		.*,
		.psel    (uart_psel),
		.prdata  (uart_prdata),
		.pready  (uart_pready),
		.pslverr (uart_pslverr)
	);

endmodule

/* src/uart_tx.sv */
// transmit-only uart
`timescale 1ns/100ps
`include "periph_params.svh"

module uart_tx #(
	parameter int clkdiv = `UART_CLKDIV  // clock cycles per bit
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  logic [`APB_AW-1:0] paddr,
	input  logic [`APB_DW-1:0] pwdata,
	output logic [`APB_DW-1:0] prdata,
	output logic               pready,
	output logic               pslverr,
	output logic               uart_tx
);
	import periph_pkg::*;

	localparam int bw = (clkdiv > 1) ? $clog2(clkdiv) : 1;

	logic [bw-1:0] baud_cnt;
	logic [9:0]    shifter;   // stop, data[7:0], start
	logic [3:0]    bit_cnt;   // bits left in the frame
	logic          busy;
	logic          tx_wr;
	logic          load;
	reg_off_e      off;

	assign off   = reg_off_e'(paddr[`OFF_MSB:`OFF_LSB]);
	assign busy  = (bit_cnt != 4'd0);
	assign tx_wr = psel && pwrite && (off == REG_TXDATA);
	assign load  = tx_wr && penable && !busy;

	// stall a txdata write until the frame in flight is out
	assign pready  = !(tx_wr && busy);
	assign uart_tx = shifter[0];

	always_comb begin
		prdata  = '0;
		pslverr = 1'b0;
		case (off)
			REG_TXDATA: ;  // write only and reads back zero
			REG_STATUS: prdata = {{(`APB_DW-1){1'b0}}, busy};
			default:    pslverr = psel && penable;
		endcase
	end

	// ---------------------------------------------------------------------
	// baud counter and shifter

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			shifter  <= '1;  // line idles high
			bit_cnt  <= '0;
			baud_cnt <= '0;
		end else if (load) begin
			shifter  <= {1'b1, pwdata[7:0], 1'b0};
			bit_cnt  <= 4'd10;
			baud_cnt <= bw'(clkdiv - 1);
		end else if (busy) begin
			if (baud_cnt == '0) begin
				shifter  <= {1'b1, shifter[9:1]};  // lsb first and fill with idle
				bit_cnt  <= bit_cnt - 4'd1;
				baud_cnt <= bw'(clkdiv - 1);
			end else begin
				baud_cnt <= baud_cnt - bw'(1);
			end
		end
	end

	// line sits at mark between frames
	assert property (@(posedge clk) disable iff (!rst_n)
		!busy |-> uart_tx)
		else $error("uart_tx: line low while idle");

endmodule

/* src/us_tick_gen.sv */
// microsecond tick generator
`timescale 1ns/100ps
`include "periph_params.svh"

module us_tick_gen #(
	parameter int tick_div = `TICK_DIV  // clock cycles per microsecond
) (
	input  logic clk,
	input  logic rst_n,
	output logic tick
);
	localparam int cw = (tick_div > 1) ? $clog2(tick_div) : 1;

	logic [cw-1:0] cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt  <= cw'(tick_div - 1);
			tick <= 1'b0;
		end else begin
			if (cnt == '0)
				cnt <= cw'(tick_div - 1);  // reload
			else
				cnt <= cnt - cw'(1);
			tick <= (cnt == '0);
		end
	end

	// a real divider never gives back-to-back ticks
	assert property (@(posedge clk) disable iff (!rst_n)
		(tick_div > 1 && tick) |=> !tick)
		else $error("us_tick_gen: tick high on two cycles in a row");

endmodule
